//--- rtl/whack_pkg.sv
`default_nettype none

package whack_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Game states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        PLAY      = 2'd1,
        GAME_OVER = 2'd2
    } game_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Four holes, one button and one LED each
    localparam int N_MOLES = 4;
    localparam int HOLE_W  = $clog2(N_MOLES);
    // Score saturates at 127
    localparam int SCORE_W = 7;
    localparam int LIVES_W = 2;
    localparam int LEVEL_W = 4;
    // Shared by every countdown
    localparam int TIMER_W = 29;
    localparam int LFSR_W  = 16;

    localparam logic [LIVES_W-1:0] START_LIVES = 2'd3;
    // Any nonzero value works
    localparam logic [LFSR_W-1:0]  LFSR_SEED   = 16'hace1;

    ////////////////////////////////////////////////////////////////////////////
    // Default timing, in clk cycles
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned DEF_DELAY_MIN   = 100_000_000;
    // Power of two, random part of the delay
    localparam int unsigned DEF_DELAY_SPAN  = 2 ** 27;
    localparam int unsigned DEF_WINDOW_BASE = 300_000_000;
    localparam int unsigned DEF_WINDOW_STEP = 24_900_000;

    // Level rule
    localparam int POINTS_PER_LEVEL = 10;
    localparam int MAX_LEVEL        = 9;

endpackage

`default_nettype wire

//--- rtl/mole_if.sv
`timescale 1ns/1ps
`default_nettype none

// Next-mole handshake between controller and scheduler
interface mole_if import whack_pkg::*; ();

    // One-cycle pulse, starts a new random delay
    logic              arm;
    // Mole scheduled and waiting
    logic              valid;
    // Controller can show a mole
    logic              ready;
    // Index of the scheduled hole
    logic [HOLE_W-1:0] hole;

    modport controller (
        output arm,
        output ready,
        input  valid,
        input  hole
    );

    modport scheduler (
        input  arm,
        input  ready,
        output valid,
        output hole
    );

endinterface

`default_nettype wire

//--- rtl/window_if.sv
`timescale 1ns/1ps
`default_nettype none

// Hit-window control between controller and window timer
interface window_if import whack_pkg::*; ();

    // Load window length and start counting
    logic               start;
    // Stop the count, no expiry
    logic               cancel;
    // Current level, sets window length
    logic [LEVEL_W-1:0] level;
    // One-cycle pulse when the window runs out
    logic               expired;

    modport controller (
        output start,
        output cancel,
        output level,
        input  expired
    );

    modport timer (
        input  start,
        input  cancel,
        input  level,
        output expired
    );

endinterface

`default_nettype wire

//--- rtl/mole_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module mole_scheduler import whack_pkg::*; #(
    parameter int unsigned DELAY_MIN  = DEF_DELAY_MIN,
    parameter int unsigned DELAY_SPAN = DEF_DELAY_SPAN
) (
    input  logic       clk,
    input  logic       reset,
    mole_if.scheduler  sched
);

    // Span is a power of two, so the random part is a plain mask
    localparam logic [TIMER_W-1:0] SPAN_MASK = TIMER_W'(DELAY_SPAN - 1);
    localparam logic [TIMER_W-1:0] MIN_TICKS = TIMER_W'(DELAY_MIN);

    logic [LFSR_W-1:0]  lfsr;
    logic [TIMER_W-1:0] rnd_wide;
    logic [TIMER_W-1:0] delay;
    logic [TIMER_W-1:0] count;
    logic               running;
    logic               transfer;

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[LFSR_W-2:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // Widen the 16-bit state to timer width, then cut to the span
    assign rnd_wide = {lfsr[TIMER_W-LFSR_W-1:0], lfsr} & SPAN_MASK;
    assign delay    = MIN_TICKS + rnd_wide;
    assign transfer = sched.valid && sched.ready;

    ////////////////////////////////////////////////////////////////////////////
    // Delay countdown and handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count       <= '0;
            running     <= 1'b0;
            sched.valid <= 1'b0;
            sched.hole  <= '0;
        end else if (sched.arm) begin
            // New arm drops any pending mole
            sched.valid <= 1'b0;
            running     <= 1'b1;
            // Valid rises delay cycles after this edge, at least one
            count       <= (delay == '0) ? '0 : delay - 1'b1;
            // Upper bits, away from the span mask
            sched.hole  <= lfsr[LFSR_W-1 -: HOLE_W];
        end else if (running) begin
            if (count == '0) begin
                running     <= 1'b0;
                sched.valid <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end else if (transfer) begin
            // Accepted, stay quiet until the next arm
            sched.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/hit_window.sv
`timescale 1ns/1ps
`default_nettype none

module hit_window import whack_pkg::*; #(
    parameter int unsigned WINDOW_BASE = DEF_WINDOW_BASE,
    parameter int unsigned WINDOW_STEP = DEF_WINDOW_STEP
) (
    input  logic      clk,
    input  logic      reset,
    window_if.timer   win
);

    localparam logic [TIMER_W-1:0] BASE_TICKS = TIMER_W'(WINDOW_BASE);
    localparam logic [TIMER_W-1:0] STEP_TICKS = TIMER_W'(WINDOW_STEP);

    logic [TIMER_W-1:0] cut;
    logic [TIMER_W-1:0] length;
    logic [TIMER_W-1:0] count;
    logic               running;

    // Each level takes one step off the base length
    assign cut    = TIMER_W'(win.level) * STEP_TICKS;
    // Never shorter than one cycle
    assign length = (cut >= BASE_TICKS) ? TIMER_W'(1) : BASE_TICKS - cut;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count       <= '0;
            running     <= 1'b0;
            win.expired <= 1'b0;
        end else begin
            win.expired <= 1'b0;
            if (win.start) begin
                count   <= length;
                running <= 1'b1;
            end else if (running) begin
                if (win.cancel) begin
                    // Player acted in time
                    running <= 1'b0;
                end else if (count == TIMER_W'(1)) begin
                    running     <= 1'b0;
                    win.expired <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm import whack_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [N_MOLES-1:0]  button,
    output logic [N_MOLES-1:0]  mole,
    output logic [SCORE_W-1:0]  score,
    output logic [LIVES_W-1:0]  lives,
    output logic [SCORE_W-1:0]  high_score,
    output game_state_t         state,
    mole_if.controller          sched,
    window_if.controller        win
);

    logic [N_MOLES-1:0] button_q;
    logic [N_MOLES-1:0] button_prev;
    logic [N_MOLES-1:0] press;
    logic               any_press;
    logic               mole_lit;
    logic               in_play;
    logic               hit;
    logic               wrong;
    logic               miss;
    logic               outcome;
    logic               transfer;
    logic               arm_q;
    logic [SCORE_W-1:0] level_raw;

    ////////////////////////////////////////////////////////////////////////////
    // Button edges
    ////////////////////////////////////////////////////////////////////////////

    // Sample, then compare with the previous sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            button_q    <= '0;
            button_prev <= '0;
        end else begin
            button_q    <= button;
            button_prev <= button_q;
        end
    end

    // One-cycle pulse per rising edge
    assign press     = button_q & ~button_prev;
    assign any_press = |press;

    ////////////////////////////////////////////////////////////////////////////
    // Outcome decode
    ////////////////////////////////////////////////////////////////////////////

    assign mole_lit = |mole;
    assign in_play  = (state == PLAY);
    // Hit wins over a simultaneous wrong press
    assign hit      = in_play && mole_lit && |(press & mole);
    assign wrong    = in_play && mole_lit && !hit && |(press & ~mole);
    assign miss     = in_play && mole_lit && !hit && !wrong && win.expired;
    // Presses on a dark field fall through here
    assign outcome  = hit || wrong || miss;
    assign transfer = sched.valid && sched.ready;

    // Accept a mole only on an empty field during play
    assign sched.ready = in_play && !mole_lit;
    assign sched.arm   = arm_q;
    // Window opens together with the mole
    assign win.start   = transfer;
    assign win.cancel  = outcome;

    // Level is score / 10, capped
    assign level_raw = score / SCORE_W'(POINTS_PER_LEVEL);
    assign win.level = (level_raw > SCORE_W'(MAX_LEVEL)) ? LEVEL_W'(MAX_LEVEL)
                                                          : LEVEL_W'(level_raw);

    ////////////////////////////////////////////////////////////////////////////
    // Game FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            score      <= '0;
            lives      <= '0;
            high_score <= '0;
            mole       <= '0;
            arm_q      <= 1'b0;
        end else begin
            // Arm is a single-cycle pulse
            arm_q <= 1'b0;
            case (state)
                IDLE: begin
                    // Any button starts a game
                    if (any_press) begin
                        state <= PLAY;
                        score <= '0;
                        lives <= START_LIVES;
                        mole  <= '0;
                        arm_q <= 1'b1;
                    end
                end

                PLAY: begin
                    if (transfer) begin
                        // Light the scheduled hole
                        mole <= N_MOLES'(1) << sched.hole;
                    end else if (hit) begin
                        if (score != {SCORE_W{1'b1}}) begin
                            score <= score + 1'b1;
                        end
                        mole  <= '0;
                        arm_q <= 1'b1;
                    end else if (wrong || miss) begin
                        if (lives == LIVES_W'(1)) begin
                            // Last life gone
                            state <= GAME_OVER;
                            lives <= '0;
                            mole  <= '1;
                            if (score > high_score) begin
                                high_score <= score;
                            end
                        end else begin
                            lives <= lives - 1'b1;
                            mole  <= '0;
                            arm_q <= 1'b1;
                        end
                    end
                end

                GAME_OVER: begin
                    // All LEDs on until a press
                    if (any_press) begin
                        state <= IDLE;
                        mole  <= '0;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/whack_a_mole_top.sv
`timescale 1ns/1ps
`default_nettype none

module whack_a_mole_top import whack_pkg::*; #(
    parameter int unsigned DELAY_MIN   = DEF_DELAY_MIN,
    parameter int unsigned DELAY_SPAN  = DEF_DELAY_SPAN,
    parameter int unsigned WINDOW_BASE = DEF_WINDOW_BASE,
    parameter int unsigned WINDOW_STEP = DEF_WINDOW_STEP
) (
    input  logic                clk,
    input  logic                reset,
    // Debounced, bit i is hole i
    input  logic [N_MOLES-1:0]  button,
    output logic [N_MOLES-1:0]  mole,
    output logic [SCORE_W-1:0]  score,
    output logic [LIVES_W-1:0]  lives,
    output logic [SCORE_W-1:0]  high_score,
    output game_state_t         state
);

    // Internal buses
    mole_if   mole_bus ();
    window_if win_bus ();

    // Game controller
    game_fsm game_fsm_i (
        .clk        (clk),
        .reset      (reset),
        .button     (button),
        .mole       (mole),
        .score      (score),
        .lives      (lives),
        .high_score (high_score),
        .state      (state),
        .sched      (mole_bus.controller),
        .win        (win_bus.controller)
    );

    // Random mole timing
    mole_scheduler #(
        .DELAY_MIN  (DELAY_MIN),
        .DELAY_SPAN (DELAY_SPAN)
    ) mole_scheduler_i (
        .clk   (clk),
        .reset (reset),
        .sched (mole_bus.scheduler)
    );

    // Whack window
    hit_window #(
        .WINDOW_BASE (WINDOW_BASE),
        .WINDOW_STEP (WINDOW_STEP)
    ) hit_window_i (
        .clk   (clk),
        .reset (reset),
        .win   (win_bus.timer)
    );

endmodule

`default_nettype wire

//--- verif/whack_a_mole_assert.sv
`timescale 1ns/1ps
`default_nettype none

module whack_a_mole_assert import whack_pkg::*; (
    input logic               clk,
    input logic               reset,
    input logic [N_MOLES-1:0] mole,
    input logic [LIVES_W-1:0] lives,
    input game_state_t        state
);

    // Failures so far, watched from the testbench
    int unsigned fail_count = 0;

    // At most one mole during play
    mole_onehot: assert property (@(posedge clk) disable iff (reset)
        (state == PLAY) |-> $onehot0(mole))
        else begin
            fail_count++;
            $error("more than one mole lit during play");
        end

    // Play never runs without a life
    play_has_lives: assert property (@(posedge clk) disable iff (reset)
        (state == PLAY) |-> (lives != '0))
        else begin
            fail_count++;
            $error("play state with zero lives");
        end

    // End screen lights every hole
    over_all_lit: assert property (@(posedge clk) disable iff (reset)
        (state == GAME_OVER) |-> (mole == '1))
        else begin
            fail_count++;
            $error("game over without all moles lit");
        end

    // Dark field whenever idle, from reset on
    idle_dark: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> (mole == '0))
        else begin
            fail_count++;
            $error("mole lit while idle");
        end

endmodule

bind whack_a_mole_top whack_a_mole_assert whack_a_mole_assert_i (
    .clk   (clk),
    .reset (reset),
    .mole  (mole),
    .lives (lives),
    .state (state)
);

`default_nettype wire

//--- verif/whack_a_mole_tb.sv
`timescale 1ns/1ps
`default_nettype none

module whack_a_mole_tb import whack_pkg::*; ();

    // Cycle limits for each kind of wait
    localparam int LIT_TIMEOUT    = 200;
    localparam int CHANGE_TIMEOUT = 600;

    typedef enum logic [1:0] {
        START,
        HIT,
        WRONG,
        MISS
    } action_t;

    // One player action and the expected result
    typedef struct {
        action_t     act;
        int          score;
        int          lives;
        game_state_t state;
        int          high;
    } step_t;

    logic               clk;
    logic               reset;
    logic [N_MOLES-1:0] button;
    logic [N_MOLES-1:0] mole;
    logic [SCORE_W-1:0] score;
    logic [LIVES_W-1:0] lives;
    logic [SCORE_W-1:0] high_score;
    game_state_t        state;
    step_t              steps[$];

    // Short timing so a game fits in a few thousand cycles
    whack_a_mole_top #(
        .DELAY_MIN   (20),
        .DELAY_SPAN  (16),
        .WINDOW_BASE (200),
        .WINDOW_STEP (10)
    ) whack_a_mole_top_i (
        .clk        (clk),
        .reset      (reset),
        .button     (button),
        .mole       (mole),
        .score      (score),
        .lives      (lives),
        .high_score (high_score),
        .state      (state)
    );

    // 20 ns period
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_run($sformatf("ERROR at %0t ns: %s is %0d, expected %0d",
                               $time, what, actual, expected));
        end
    endtask

    // Bound assertions count their failures
    always @(whack_a_mole_top_i.whack_a_mole_assert_i.fail_count) begin
        if (whack_a_mole_top_i.whack_a_mole_assert_i.fail_count != 0) begin
            stop_run("A bound assertion on the top-level ports failed");
        end
    end

    task automatic add_step(input action_t act, input int sc, input int lv,
                            input game_state_t st, input int hi);
        step_t s;
        s.act   = act;
        s.score = sc;
        s.lives = lv;
        s.state = st;
        s.high  = hi;
        steps.push_back(s);
    endtask

    // One-cycle press, driven just after the edge
    task automatic press_button(input logic [N_MOLES-1:0] pattern);
        button = pattern;
        @(posedge clk);
        #2;
        button = '0;
    endtask

    task automatic wait_for_mole(output logic [N_MOLES-1:0] lit);
        int cycles;
        cycles = 0;
        while (mole == '0) begin
            if (cycles == LIT_TIMEOUT) begin
                stop_run("Timeout: no mole appeared while the game was running");
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        lit = mole;
    endtask

    task automatic wait_for_mole_change(input logic [N_MOLES-1:0] old);
        int cycles;
        cycles = 0;
        while (mole == old) begin
            if (cycles == CHANGE_TIMEOUT) begin
                stop_run("Timeout: the lit mole never changed after the player action");
            end
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    task automatic wait_for_state_change(input game_state_t old);
        int cycles;
        cycles = 0;
        while (state == old) begin
            if (cycles == CHANGE_TIMEOUT) begin
                stop_run("Timeout: the game state did not change after a button press");
            end
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    // Rotate the lit hole by 1..3 places, never the lit one
    function automatic logic [N_MOLES-1:0] wrong_hole(input logic [N_MOLES-1:0] lit,
                                                      input int offset);
        int idx;
        idx = 0;
        for (int i = 0; i < N_MOLES; i++) begin
            if (lit[i]) begin
                idx = i;
            end
        end
        return N_MOLES'(1) << ((idx + offset) % N_MOLES);
    endfunction

    task automatic apply_step(input step_t s, input int num);
        logic [N_MOLES-1:0] lit;
        game_state_t        old_state;
        case (s.act)
            START: begin
                old_state = state;
                press_button(4'b0001);
                wait_for_state_change(old_state);
            end
            HIT: begin
                wait_for_mole(lit);
                press_button(lit);
                wait_for_mole_change(lit);
            end
            WRONG: begin
                wait_for_mole(lit);
                press_button(wrong_hole(lit, int'($urandom % 3) + 1));
                wait_for_mole_change(lit);
            end
            default: begin
                // Miss, just let the window run out
                wait_for_mole(lit);
                wait_for_mole_change(lit);
            end
        endcase
        check_value(score, s.score, $sformatf("step %0d score", num));
        check_value(lives, s.lives, $sformatf("step %0d lives", num));
        check_value(state, s.state, $sformatf("step %0d state", num));
        check_value(high_score, s.high, $sformatf("step %0d high_score", num));
        // All lit in game over, dark right after any other decision
        check_value(mole, (s.state == GAME_OVER) ? 4'hf : 4'h0,
                    $sformatf("step %0d mole", num));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        add_step(START, 0, 3, PLAY, 0);
        // Twelve hits, crossing into level 1
        for (int i = 1; i <= 12; i++) begin
            add_step(HIT, i, 3, PLAY, 0);
        end
        add_step(WRONG, 12, 2, PLAY, 0);
        add_step(MISS, 12, 1, PLAY, 0);
        add_step(WRONG, 12, 0, GAME_OVER, 12);
        add_step(START, 12, 0, IDLE, 12);
        // Second, shorter game
        add_step(START, 0, 3, PLAY, 12);
        add_step(HIT, 1, 3, PLAY, 12);
        add_step(HIT, 2, 3, PLAY, 12);
        add_step(MISS, 2, 2, PLAY, 12);
        add_step(WRONG, 2, 1, PLAY, 12);
        add_step(MISS, 2, 0, GAME_OVER, 12);
        add_step(START, 2, 0, IDLE, 12);
    endtask

    initial begin
        void'($urandom(32'hd2cd));
        clk    = 1'b0;
        reset  = 1'b1;
        button = '0;
        build_table();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        // Power-up values
        check_value(state, IDLE, "reset state");
        check_value(score, 0, "reset score");
        check_value(lives, 0, "reset lives");
        check_value(high_score, 0, "reset high_score");
        check_value(mole, 0, "reset mole");
        foreach (steps[i]) begin
            apply_step(steps[i], i);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/whack_pkg.sv
rtl/mole_if.sv
rtl/window_if.sv
rtl/mole_scheduler.sv
rtl/hit_window.sv
rtl/game_fsm.sv
rtl/whack_a_mole_top.sv
verif/whack_a_mole_assert.sv
verif/whack_a_mole_tb.sv

//--- Bender.yml
package:
  name: whack_a_mole

sources:
  - rtl/whack_pkg.sv
  - rtl/mole_if.sv
  - rtl/window_if.sv
  - rtl/mole_scheduler.sv
  - rtl/hit_window.sv
  - rtl/game_fsm.sv
  - rtl/whack_a_mole_top.sv
  - target: simulation
    files:
      - verif/whack_a_mole_assert.sv
      - verif/whack_a_mole_tb.sv
